// ==== Makefile ====
# Verilator build and run of the spi master testbench

VERILATOR ?= verilator
TOP       ?= spi_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/spi_clkgen.sv ====
// testbench clock and reset source: 20 ns clk, nreset low for two cycles
`timescale 1ns/1ps

module spi_clkgen (
   output logic clk,
   output logic nreset
);

   localparam int HALF_NS     = 10;   // 20 ns period
   localparam int RESET_EDGES = 2;

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   initial begin
      nreset = 1'b0;
      repeat (RESET_EDGES) @(posedge clk);
      #1;
      nreset = 1'b1;                // released just after an edge
   end

endmodule

// ==== bench/spi_tb.sv ====
// spi master testbench: dut with mosi/miso loopback, bus tasks, checks, directed tests, watchdog
`timescale 1ns/1ps

module spi_tb import spi_pkg::*; ();

   localparam logic [31:0] SEED = 32'hf827_2f78;
   localparam int CLKDIV_BIG   = 20;                          // back-pressure test
   localparam int FRAME_CYCLES = 18 * (CLKDIV_BIG + 1) + 8;   // ss low to idle, worst case
   localparam int N_FRAMES     = 13;                          // 4 + 2 + 6 + 1
   localparam int TIMEOUT_NS   = 2 * N_FRAMES * FRAME_CYCLES * 20 + 50_000;

   logic      clk;
   logic      nreset;
   logic      access_in;
   logic      write_in;
   reg_addr_t addr_in;
   reg_data_t wdata_in;
   logic      wait_in;
   logic      access_out;
   reg_data_t rdata_out;
   logic      wait_out;
   logic      sclk;
   logic      ss;
   logic      mosi;

   logic [31:0] rng = SEED;
   int          errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   logic        saw_wait = 1'b0;    // wait_out seen by a bus task
   logic        cur_cpol = 1'b0;    // mode as last written
   logic        cur_cpha = 1'b0;
   spi_byte_t   mosi_shift = '0;
   int          mosi_bits = 0;
   spi_byte_t   mosi_bytes[$];      // rebuilt, first bit in msb
   spi_byte_t   exp_bytes[$];

   spi_clkgen clkgen_i (.clk(clk), .nreset(nreset));

   spi_master spi_master_i (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .write_in   (write_in),
      .addr_in    (addr_in),
      .wdata_in   (wdata_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .rdata_out  (rdata_out),
      .wait_out   (wait_out),
      .sclk       (sclk),
      .ss         (ss),
      .mosi       (mosi),
      .miso       (mosi)             // loopback
   );

   //############################################################
   //# mosi monitor
   //############################################################

   always @(negedge ss)
      mosi_bits = 0;                  // new frame

   always @(sclk) begin
      if (ss === 1'b0) begin
         #1;                          // let pins settle
         if (((sclk != cur_cpol) ^ cur_cpha) == 1'b1) begin
            mosi_shift = {mosi_shift[6:0], mosi};
            mosi_bits++;
            if (mosi_bits == 8)
               mosi_bytes.push_back(mosi_shift);
         end
      end
   end

   //############################################################
   //# helpers and checks
   //############################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic spi_byte_t next_byte();
      rng = xorshift32(rng);
      return rng[7:0];
   endfunction

   function automatic spi_byte_t reverse_bits(input spi_byte_t b);
      spi_byte_t r;
      for (int i = 0; i < 8; i++)
         r[i] = b[7-i];
      return r;
   endfunction

   task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // rebuilt mosi stream against the expected queue
   task automatic check_mosi(input string name);
      if (mosi_bytes.size() != exp_bytes.size()) begin
         errors++;
         $display("%s: %0d bytes seen on mosi where %0d were sent", name,
                  mosi_bytes.size(), exp_bytes.size());
      end else begin
         foreach (exp_bytes[i])
            check_byte(name, exp_bytes[i], mosi_bytes[i]);
      end
   endtask

   task automatic finish_test(input string name, input int err0);
      if (errors == err0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err0);
      end
   endtask

   //############################################################
   //# bus tasks, entered and left 1 ns after a rising edge
   //############################################################

   task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
      logic ok;
      access_in = 1'b1;
      write_in  = 1'b1;
      addr_in   = addr;
      wdata_in  = data;
      do begin
         @(negedge clk);
         ok = !wait_out;              // holds until the next edge
         if (wait_out)
            saw_wait = 1'b1;
         @(posedge clk);
         #1;
      end while (!ok);
      access_in = 1'b0;
   endtask

   task automatic bus_read(input string name, input reg_addr_t addr, output reg_data_t data);
      logic ok;
      access_in = 1'b1;
      write_in  = 1'b0;
      addr_in   = addr;
      wdata_in  = '0;
      do begin
         @(negedge clk);
         ok = !wait_out;
         if (wait_out)
            saw_wait = 1'b1;
         @(posedge clk);
         #1;
      end while (!ok);
      access_in = 1'b0;
      @(negedge clk);                 // one cycle after acceptance
      if (access_out !== 1'b1) begin
         errors++;
         $display("%s: no read return one cycle after reading offset 0x%02h", name, addr);
      end
      data = rdata_out;
      @(posedge clk);
      #1;
   endtask

   task automatic set_mode(input logic pol, input logic pha, input logic lsb, input logic dis);
      reg_data_t cfg;
      cfg = '0;
      cfg[CFG_DISABLE]  = dis;
      cfg[CFG_CPOL]     = pol;
      cfg[CFG_CPHA]     = pha;
      cfg[CFG_LSBFIRST] = lsb;
      cur_cpol = pol;
      cur_cpha = pha;
      bus_write(SPI_CONFIG, cfg);
   endtask

   // poll status until the sticky rx flag shows up
   task automatic wait_rx_flag(input string name);
      reg_data_t st;
      st = '0;
      while (!st[ST_RXVALID])
         bus_read(name, SPI_STATUS, st);
   endtask

   task automatic send_byte(input string name, input spi_byte_t tx);
      reg_data_t d;
      bus_write(SPI_STATUS, '0);      // clear rx flag
      bus_write(SPI_TX, {24'h0, tx});
      wait_rx_flag(name);
      bus_read(name, SPI_RX, d);
      check_data(name, {24'h0, tx}, d);
   endtask

   //############################################################
   //# directed tests
   //############################################################

   task automatic test_reset();
      reg_data_t d;
      int        err0;
      err0 = errors;
      bus_read("reset config", SPI_CONFIG, d);
      check_data("reset config", '0, d);
      bus_read("reset clkdiv", SPI_CLKDIV, d);
      check_data("reset clkdiv", {24'h0, CLKDIV_RESET}, d);
      bus_read("reset status", SPI_STATUS, d);
      check_data("reset status", '0, d);
      @(negedge clk);
      check_bit("reset ss", 1'b1, ss);
      check_bit("reset sclk", 1'b0, sclk);
      @(posedge clk);
      #1;
      finish_test("reset", err0);
   endtask

   task automatic test_regs();
      reg_data_t d;
      int        err0;
      err0 = errors;
      bus_write(SPI_CONFIG, 32'h1234_56f6);      // bit 0 clear, stays enabled
      bus_read("regs config", SPI_CONFIG, d);
      check_data("regs config", 32'h0000_00f6, d);
      bus_write(SPI_CONFIG, '0);
      bus_write(SPI_CLKDIV, 32'hcafe_0107);
      bus_read("regs clkdiv", SPI_CLKDIV, d);
      check_data("regs clkdiv", 32'h0000_0007, d);
      bus_read("regs tx", SPI_TX, d);
      check_data("regs tx", '0, d);
      // stalled return
      wait_in = 1'b1;
      bus_read("regs wait_in", SPI_CLKDIV, d);
      check_data("regs wait_in", 32'h0000_0007, d);
      repeat (3) begin
         @(negedge clk);
         check_bit("regs held access_out", 1'b1, access_out);
         check_bit("regs held wait_out", 1'b1, wait_out);
         check_data("regs held rdata", 32'h0000_0007, rdata_out);
         @(posedge clk);
         #1;
      end
      wait_in = 1'b0;
      @(negedge clk);
      check_bit("regs release access_out", 1'b1, access_out);   // taken at next edge
      @(posedge clk);
      #1;
      @(negedge clk);
      check_bit("regs taken access_out", 1'b0, access_out);
      @(posedge clk);
      #1;
      finish_test("registers", err0);
   endtask

   task automatic test_loopback();
      spi_byte_t tx;
      int        err0;
      err0 = errors;
      for (int m = 0; m < 4; m++) begin
         set_mode(m[1], m[0], 1'b0, 1'b0);
         bus_write(SPI_CLKDIV, 32'd2);
         @(negedge clk);
         check_bit($sformatf("loopback mode %0d idle sclk", m), m[1], sclk);
         @(posedge clk);
         #1;
         mosi_bytes.delete();
         exp_bytes.delete();
         tx = next_byte();
         exp_bytes.push_back(tx);
         send_byte($sformatf("loopback mode %0d rx", m), tx);
         check_mosi($sformatf("loopback mode %0d mosi", m));
      end
      finish_test("loopback", err0);
   endtask

   task automatic test_bit_order();
      spi_byte_t tx;
      int        err0;
      err0 = errors;
      bus_write(SPI_CLKDIV, 32'd1);
      for (int lsb = 0; lsb < 2; lsb++) begin
         set_mode(1'b0, 1'b0, lsb[0], 1'b0);
         mosi_bytes.delete();
         exp_bytes.delete();
         tx = next_byte();
         exp_bytes.push_back(lsb ? reverse_bits(tx) : tx);   // first bit lands in msb
         send_byte($sformatf("bit order lsbfirst %0d rx", lsb), tx);
         check_mosi($sformatf("bit order lsbfirst %0d mosi", lsb));
      end
      finish_test("bit order", err0);
   endtask

   task automatic test_backpressure();
      reg_data_t d;
      spi_byte_t tx;
      int        err0;
      err0 = errors;
      set_mode(1'b0, 1'b0, 1'b0, 1'b0);
      bus_write(SPI_CLKDIV, CLKDIV_BIG);
      bus_write(SPI_STATUS, '0);
      mosi_bytes.delete();
      exp_bytes.delete();
      saw_wait = 1'b0;
      for (int i = 0; i < 6; i++) begin
         tx = next_byte();
         exp_bytes.push_back(tx);
         bus_write(SPI_TX, {24'h0, tx});           // one in flight, four queued
      end
      check_bit("back-pressure wait_out", 1'b1, saw_wait);
      bus_read("back-pressure status", SPI_STATUS, d);   // returns once a slot frees
      check_bit("back-pressure full", 1'b1, d[ST_FULL]);
      while (mosi_bytes.size() < 6)
         @(posedge clk);
      #1;
      do
         bus_read("back-pressure idle", SPI_STATUS, d);
      while (d[ST_BUSY]);
      check_data("back-pressure end status", 32'h0000_0001, d);
      check_mosi("back-pressure mosi");
      bus_read("back-pressure rx", SPI_RX, d);
      check_data("back-pressure rx", {24'h0, exp_bytes[5]}, d);
      bus_write(SPI_STATUS, 32'h0000_00ff);        // any value clears
      bus_read("back-pressure clear", SPI_STATUS, d);
      check_data("back-pressure clear", '0, d);
      finish_test("back-pressure", err0);
   endtask

   task automatic test_disable();
      reg_data_t d;
      spi_byte_t tx;
      logic      ss_low;
      int        err0;
      err0 = errors;
      set_mode(1'b0, 1'b0, 1'b0, 1'b1);
      bus_write(SPI_CLKDIV, 32'd1);
      bus_write(SPI_STATUS, '0);
      mosi_bytes.delete();
      exp_bytes.delete();
      tx = next_byte();
      exp_bytes.push_back(tx);
      bus_write(SPI_TX, {24'h0, tx});
      ss_low = 1'b0;
      repeat (40) begin                           // observation window, no frame expected
         @(negedge clk);
         if (ss !== 1'b1)
            ss_low = 1'b1;
         @(posedge clk);
         #1;
      end
      check_bit("disable ss went low", 1'b0, ss_low);
      bus_read("disable status", SPI_STATUS, d);
      check_data("disable status", '0, d);
      set_mode(1'b0, 1'b0, 1'b0, 1'b0);            // queued byte goes now
      wait_rx_flag("disable resume");
      bus_read("disable rx", SPI_RX, d);
      check_data("disable rx", {24'h0, tx}, d);
      check_mosi("disable mosi");
      finish_test("disable", err0);
   endtask

   //############################################################
   //# run and watchdog
   //############################################################

   initial begin
      access_in = 1'b0;
      write_in  = 1'b0;
      addr_in   = '0;
      wdata_in  = '0;
      wait_in   = 1'b0;
      wait (nreset === 1'b1);
      @(posedge clk);
      #1;
      test_reset();
      test_regs();
      test_loopback();
      test_bit_order();
      test_backpressure();
      test_disable();
      $display("tests passed %0d, failed %0d, check errors %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== bench/spi_tb_properties.sv ====
// bound checks on the spi master for idle pins, read return timing and mosi on sampling edges
`timescale 1ns/1ps

module spi_tb_properties (
   input logic clk,
   input logic nreset,
   input logic access_in,
   input logic write_in,
   input logic wait_in,
   input logic access_out,
   input logic wait_out,
   input logic busy,       // shifter not idle
   input logic cpol,       // config bit inside the dut
   input logic cpha,
   input logic sclk,
   input logic ss,
   input logic mosi
);

   // idle means deselected with sclk one cycle behind cpol
   idle_pins: assert property (@(posedge clk) disable iff (!nreset)
      !busy |-> (ss && (sclk == $past(cpol))))
      else $error("idle pins wrong, ss %b sclk %b", ss, sclk);

   // return only after an accepted read or while stalled
   read_return: assert property (@(posedge clk) disable iff (!nreset)
      access_out |-> ($past(access_in && !wait_out && !write_in) ||
                      $past(access_out && wait_in)))
      else $error("access_out without an accepted read");

   // leading edge samples with cpha 0 and trailing edge with cpha 1
   mosi_stable: assert property (@(posedge clk) disable iff (!nreset)
      (!ss && (sclk != $past(sclk)) && ((sclk != cpol) ^ cpha)) |-> (mosi == $past(mosi)))
      else $error("mosi moved on a sampling edge");

endmodule

bind spi_master spi_tb_properties props_i (
   .clk        (clk),
   .nreset     (nreset),
   .access_in  (access_in),
   .write_in   (write_in),
   .wait_in    (wait_in),
   .access_out (access_out),
   .wait_out   (wait_out),
   .busy       (busy),
   .cpol       (cpol),
   .cpha       (cpha),
   .sclk       (sclk),
   .ss         (ss),
   .mosi       (mosi)
);

// ==== build.f ====
rtl/spi_pkg.sv
rtl/spi_tx_fifo.sv
rtl/spi_shifter.sv
rtl/spi_master_regs.sv
rtl/spi_master.sv
bench/spi_clkgen.sv
bench/spi_tb_properties.sv
bench/spi_tb.sv

// ==== rtl/spi_master.sv ====
// spi master top: register file, tx fifo and shifter
`timescale 1ns/1ps

module spi_master import spi_pkg::*; (
   input  logic      clk,        // core clock
   input  logic      nreset,     // async, active low

   // register bus
   input  logic      access_in,
   input  logic      write_in,
   input  reg_addr_t addr_in,
   input  reg_data_t wdata_in,
   input  logic      wait_in,
   output logic      access_out,
   output reg_data_t rdata_out,
   output logic      wait_out,

   // spi pins
   output logic      sclk,
   output logic      ss,
   output logic      mosi,
   input  logic      miso
);

   logic      fifo_push;
   spi_byte_t fifo_data;         // regs to fifo
   spi_byte_t pop_data;          // fifo to shifter
   logic      fifo_pop;
   logic      fifo_empty;
   logic      fifo_full;
   logic      busy;
   logic      rx_valid;
   spi_byte_t rx_byte;
   logic      spi_en;
   logic      cpol;
   logic      cpha;
   logic      lsbfirst;
   clkdiv_t   clkdiv;

   //############################################################
   //# register file
   //############################################################

   spi_master_regs regs_i (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .write_in   (write_in),
      .addr_in    (addr_in),
      .wdata_in   (wdata_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .rdata_out  (rdata_out),
      .wait_out   (wait_out),
      .fifo_full  (fifo_full),
      .busy       (busy),
      .rx_valid   (rx_valid),
      .rx_byte    (rx_byte),
      .fifo_push  (fifo_push),
      .fifo_data  (fifo_data),
      .spi_en     (spi_en),
      .cpol       (cpol),
      .cpha       (cpha),
      .lsbfirst   (lsbfirst),
      .clkdiv     (clkdiv)
   );

   //############################################################
   //# datapath
   //############################################################

   spi_tx_fifo fifo_i (
      .clk       (clk),
      .nreset    (nreset),
      .push      (fifo_push),
      .push_data (fifo_data),
      .pop       (fifo_pop),
      .pop_data  (pop_data),
      .empty     (fifo_empty),
      .full      (fifo_full)
   );

   spi_shifter shifter_i (
      .clk        (clk),
      .nreset     (nreset),
      .spi_en     (spi_en),
      .cpol       (cpol),
      .cpha       (cpha),
      .lsbfirst   (lsbfirst),
      .clkdiv     (clkdiv),
      .fifo_empty (fifo_empty),
      .fifo_data  (pop_data),
      .fifo_pop   (fifo_pop),
      .busy       (busy),
      .rx_valid   (rx_valid),
      .rx_byte    (rx_byte),
      .sclk       (sclk),
      .ss         (ss),
      .mosi       (mosi),
      .miso       (miso)
   );

endmodule

// ==== rtl/spi_master_regs.sv ====
// spi master register file: access decode, config/clkdiv/status/rx registers, read return, wait
`timescale 1ns/1ps

module spi_master_regs import spi_pkg::*; (
   input  logic      clk,        // core clock
   input  logic      nreset,     // async, active low

   // register bus from core
   input  logic      access_in,  // request
   input  logic      write_in,   // 1 write, 0 read
   input  reg_addr_t addr_in,    // register offset
   input  reg_data_t wdata_in,   // write data, low byte used
   input  logic      wait_in,    // core stalls the return

   // read return to core
   output logic      access_out, // return valid
   output reg_data_t rdata_out,  // return data
   output logic      wait_out,   // back-pressure to core

   // datapath status
   input  logic      fifo_full,
   input  logic      busy,
   input  logic      rx_valid,   // one cycle at end of frame
   input  spi_byte_t rx_byte,

   // tx fifo push
   output logic      fifo_push,
   output spi_byte_t fifo_data,

   // mode to shifter
   output logic      spi_en,
   output logic      cpol,
   output logic      cpha,
   output logic      lsbfirst,
   output clkdiv_t   clkdiv
);

   spi_byte_t config_reg;
   clkdiv_t   clkdiv_reg;
   spi_byte_t rx_reg;
   spi_byte_t status_byte;
   spi_byte_t rd_byte;
   logic      rxvalid_q;          // sticky rx flag
   logic      busy_q;
   logic      full_q;
   logic      accept;
   logic      wr_accept;
   logic      rd_accept;

   //############################################################
   //# decode
   //############################################################

   // stalled return or full fifo holds the core off
   assign wait_out  = fifo_full | (access_out & wait_in);

   assign accept    = access_in & ~wait_out;
   assign wr_accept = accept & write_in;
   assign rd_accept = accept & ~write_in;

   assign fifo_push = wr_accept & (addr_in == SPI_TX);
   assign fifo_data = wdata_in[7:0];

   //############################################################
   //# config and clkdiv
   //############################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         config_reg <= '0;            // enabled, mode 0, msb first
         clkdiv_reg <= CLKDIV_RESET;
      end else if (wr_accept) begin
         if (addr_in == SPI_CONFIG)
            config_reg <= wdata_in[7:0];
         if (addr_in == SPI_CLKDIV)
            clkdiv_reg <= wdata_in[7:0];
      end
   end

   assign spi_en   = ~config_reg[CFG_DISABLE];
   assign cpol     = config_reg[CFG_CPOL];
   assign cpha     = config_reg[CFG_CPHA];
   assign lsbfirst = config_reg[CFG_LSBFIRST];
   assign clkdiv   = clkdiv_reg;

   //############################################################
   //# status and rx
   //############################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rxvalid_q <= 1'b0;
         busy_q    <= 1'b0;
         full_q    <= 1'b0;
      end else begin
         busy_q <= busy;              // live copies, every cycle
         full_q <= fifo_full;
         if (wr_accept && (addr_in == SPI_STATUS))
            rxvalid_q <= 1'b0;        // write of any value clears
         else if (rx_valid)
            rxvalid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid)
         rx_reg <= rx_byte;           // last frame only
   end

   always_comb begin
      status_byte              = '0;
      status_byte[ST_RXVALID]  = rxvalid_q;
      status_byte[ST_BUSY]     = busy_q;
      status_byte[ST_FULL]     = full_q;
   end

   //############################################################
   //# read return
   //############################################################

   always_comb begin
      case (addr_in)
         SPI_CONFIG: rd_byte = config_reg;
         SPI_STATUS: rd_byte = status_byte;
         SPI_CLKDIV: rd_byte = clkdiv_reg;
         SPI_RX:     rd_byte = rx_reg;
         default:    rd_byte = '0;    // tx and unmapped read 0
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         access_out <= 1'b0;
      else if (rd_accept)
         access_out <= 1'b1;          // one cycle after acceptance
      else if (!(access_out && wait_in))
         access_out <= 1'b0;          // taken by core
   end

   // no new read gets in while stalled, so data holds by itself
   always_ff @(posedge clk) begin
      if (rd_accept)
         rdata_out <= reg_data_t'(rd_byte);
   end

endmodule

// ==== rtl/spi_pkg.sv ====
// spi master package: register offsets, config and status bits, widths, types, shifter states
package spi_pkg;

   //############################################################
   //# widths
   //############################################################

   typedef logic [7:0]  reg_addr_t;      // register offset
   typedef logic [31:0] reg_data_t;      // bus data word
   typedef logic [7:0]  spi_byte_t;      // one spi frame
   typedef logic [7:0]  clkdiv_t;        // half-period divider

   //############################################################
   //# register map
   //############################################################

   localparam reg_addr_t SPI_CONFIG = 8'h00;  // mode bits
   localparam reg_addr_t SPI_STATUS = 8'h01;  // rx flag, busy, full
   localparam reg_addr_t SPI_CLKDIV = 8'h02;  // sclk divider
   localparam reg_addr_t SPI_TX     = 8'h04;  // write pushes tx fifo
   localparam reg_addr_t SPI_RX     = 8'h08;  // last received byte

   // config bits
   localparam int CFG_DISABLE  = 0;      // 0 means spi on
   localparam int CFG_CPOL     = 1;      // sclk idle level
   localparam int CFG_CPHA     = 2;      // sample on trailing edge
   localparam int CFG_LSBFIRST = 3;      // bit order

   // status bits
   localparam int ST_RXVALID = 0;        // sticky, any status write clears
   localparam int ST_BUSY    = 1;        // frame in progress
   localparam int ST_FULL    = 2;        // tx fifo full

   localparam clkdiv_t CLKDIV_RESET = 8'd1;  // divider after reset

   //############################################################
   //# tx fifo
   //############################################################

   localparam int FIFO_DEPTH = 4;                    // power of two
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;        // wraps naturally
   typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;        // 0..FIFO_DEPTH

   //############################################################
   //# shifter
   //############################################################

   typedef logic [4:0] edge_cnt_t;                   // sclk edges seen
   localparam edge_cnt_t FRAME_EDGES = 5'd16;        // two per bit

   typedef enum logic [1:0] {
      st_idle,   // ss high, sclk at cpol
      st_setup,  // ss low, waiting for first edge
      st_shift,  // toggling sclk
      st_hold    // ss release and deselect gap
   } spi_state_t;

endpackage

// ==== rtl/spi_shifter.sv ====
// spi shifter: clock divider, frame fsm, shift register, registered sclk/ss/mosi, miso sampling
`timescale 1ns/1ps

module spi_shifter import spi_pkg::*; (
   input  logic      clk,        // core clock
   input  logic      nreset,     // async, active low

   // mode, applied at frame start
   input  logic      spi_en,
   input  logic      cpol,
   input  logic      cpha,
   input  logic      lsbfirst,
   input  clkdiv_t   clkdiv,

   // tx fifo
   input  logic      fifo_empty,
   input  spi_byte_t fifo_data,
   output logic      fifo_pop,

   output logic      busy,       // not idle
   output logic      rx_valid,   // one cycle at end of frame
   output spi_byte_t rx_byte,

   // pins
   output logic      sclk,
   output logic      ss,         // active low
   output logic      mosi,
   input  logic      miso
);

   spi_state_t state;
   clkdiv_t    div_cnt;
   clkdiv_t    div_f;            // divider for this frame
   logic       cpha_f;
   logic       lsb_f;
   edge_cnt_t  edge_cnt;
   edge_cnt_t  edge_next;
   logic       tick;             // end of a half-period
   logic       sample_edge;
   spi_byte_t  shreg;            // tx out one end, rx in the other

   assign busy        = (state != st_idle);
   assign fifo_pop    = (state == st_idle) & spi_en & ~fifo_empty;
   assign tick        = (div_cnt == div_f);
   assign edge_next   = edge_cnt + 1'b1;
   // odd edges are leading, cpha picks which one samples
   assign sample_edge = edge_next[0] ^ cpha_f;
   assign rx_byte     = shreg;

   //############################################################
   //# half-period divider
   //############################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         div_cnt <= '0;
      else if ((state == st_idle) || tick)
         div_cnt <= '0;               // clkdiv+1 cycles per half
      else
         div_cnt <= clkdiv_t'(div_cnt + 1'b1);
   end

   //############################################################
   //# frame fsm and pins
   //############################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state    <= st_idle;
         sclk     <= 1'b0;
         ss       <= 1'b1;
         mosi     <= 1'b0;
         rx_valid <= 1'b0;
         edge_cnt <= '0;
         div_f    <= CLKDIV_RESET;
         cpha_f   <= 1'b0;
         lsb_f    <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            st_idle: begin
               sclk     <= cpol;          // idle level follows config
               ss       <= 1'b1;
               edge_cnt <= '0;
               if (fifo_pop) begin
                  div_f  <= clkdiv;       // freeze mode for the frame
                  cpha_f <= cpha;
                  lsb_f  <= lsbfirst;
                  mosi   <= lsbfirst ? fifo_data[0] : fifo_data[7];
                  ss     <= 1'b0;         // one half-period before edge 1
                  state  <= st_setup;
               end
            end
            st_setup, st_shift: begin
               if (tick) begin
                  if (edge_cnt == FRAME_EDGES) begin
                     ss    <= 1'b1;       // half-period after last edge
                     state <= st_hold;
                  end else begin
                     sclk     <= ~sclk;
                     edge_cnt <= edge_next;
                     state    <= st_shift;
                     if (!sample_edge)
                        mosi <= lsb_f ? shreg[0] : shreg[7];   // next bit out
                  end
               end
            end
            st_hold: begin
               if (tick) begin
                  rx_valid <= 1'b1;       // deselect gap done
                  state    <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   //############################################################
   //# shift register
   //############################################################

   always_ff @(posedge clk) begin
      if (fifo_pop)
         shreg <= fifo_data;
      else if ((state == st_setup || state == st_shift) && tick &&
               (edge_cnt != FRAME_EDGES) && sample_edge) begin
         if (lsb_f)
            shreg <= {miso, shreg[7:1]};  // lsb leaves, miso enters top
         else
            shreg <= {shreg[6:0], miso};  // msb leaves, miso enters bottom
      end
   end

endmodule

// ==== rtl/spi_tx_fifo.sv ====
// tx byte fifo: circular buffer with read/write pointers, count, empty and full
`timescale 1ns/1ps

module spi_tx_fifo import spi_pkg::*; (
   input  logic      clk,        // core clock
   input  logic      nreset,     // async, active low

   input  logic      push,       // write side, from register file
   input  spi_byte_t push_data,

   input  logic      pop,        // read side, from shifter
   output spi_byte_t pop_data,   // head entry, valid when not empty

   output logic      empty,
   output logic      full
);

   spi_byte_t mem [FIFO_DEPTH];  // payload only
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   fifo_cnt_t count;
   logic      do_push;
   logic      do_pop;

   assign empty   = (count == '0);
   assign full    = (count == fifo_cnt_t'(FIFO_DEPTH));

   // guards keep the pointers sane on a stray request
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   //############################################################
   //# storage
   //############################################################

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   assign pop_data = mem[rd_ptr];   // show-ahead

   //############################################################
   //# pointers and count
   //############################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= fifo_ptr_t'(wr_ptr + 1'b1);   // wraps at depth
         if (do_pop)
            rd_ptr <= fifo_ptr_t'(rd_ptr + 1'b1);
         case ({do_push, do_pop})
            2'b10:   count <= fifo_cnt_t'(count + 1'b1);
            2'b01:   count <= fifo_cnt_t'(count - 1'b1);
            default: count <= count;              // none or both
         endcase
      end
   end

endmodule
